/* files.f */
rtl/soc_pkg.sv
rtl/slv_if.sv
rtl/bus_decoder.sv
rtl/sram_slave.sv
rtl/sys_regs.sv
rtl/rsp_mux.sv
rtl/soc_fabric.sv
sim/tb_soc_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build the bus fabric testbench with Verilator and run it.
# Exits with 0 only when the simulation prints its pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_soc_fabric -Mdir obj_dir -f files.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_soc_fabric)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sim/fabric_vectors.txt */
// columns, hex: write addr wdata strb expected_data expected_resp
// resp codes: 0 okay, 2 slave error, 3 decode error
1 00000010 00112233445566778899aabbccddeeff ffff 00000000000000000000000000000000 0
0 00000010 00000000000000000000000000000000 0000 00112233445566778899aabbccddeeff 0
1 00000010 ffeeddccbbaa99887766554433221100 00ff 00000000000000000000000000000000 0
0 00000010 00000000000000000000000000000000 0000 00112233445566777766554433221100 0
1 00000020 0123456789abcdef0123456789abcdef ffff 00000000000000000000000000000000 0
0 00000020 00000000000000000000000000000000 0000 0123456789abcdef0123456789abcdef 0
0 00001010 00000000000000000000000000000000 0000 00112233445566777766554433221100 0
1 10000000 deadbeefdeadbeefdeadbeefcafef00d ffff 00000000000000000000000000000000 0
0 10000000 00000000000000000000000000000000 0000 000000000000000000000000cafef00d 0
1 10000000 0000000000000000000000000000a5a5 0003 00000000000000000000000000000000 0
0 10000000 00000000000000000000000000000000 0000 000000000000000000000000cafea5a5 0
0 10000020 00000000000000000000000000000000 0000 0000000000000000000000005f1a0c91 0
1 10000020 ffffffffffffffffffffffffffffffff ffff 00000000000000000000000000000000 2
0 10000020 00000000000000000000000000000000 0000 0000000000000000000000005f1a0c91 0
1 10000010 00000000000000000000000000000007 ffff 00000000000000000000000000000000 2
0 10000030 00000000000000000000000000000000 0000 00000000000000000000000000000000 0
1 10000030 00000000000000000000000012345678 ffff 00000000000000000000000000000000 0
0 10000010 00000000000000000000000000000000 0000 00000000000000000000000000000000 0
0 20000000 00000000000000000000000000000000 0000 00000000000000000000000000000000 3
1 f0000040 0000000000000000000000000000abcd ffff 00000000000000000000000000000000 3
0 70000010 00000000000000000000000000000000 0000 00000000000000000000000000000000 3
0 10000010 00000000000000000000000000000000 0000 00000000000000000000000000000003 0
0 00000020 00000000000000000000000000000000 0000 0123456789abcdef0123456789abcdef 0
0 10000000 00000000000000000000000000000000 0000 000000000000000000000000cafea5a5 0

/* sim/tb_soc_fabric.sv */
//**********************************************************
// Testbench for the bus fabric. Replays the transactions in
// sim/fabric_vectors.txt under random response back-pressure
// and checks each reply against its expected data and code.
//**********************************************************

`timescale 1ns/100ps

module tb_soc_fabric import soc_pkg::*;;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              i_req_valid;
  logic              o_req_ready;
  logic              i_req_write;
  logic [ADDR_W-1:0] i_req_addr;
  logic [DATA_W-1:0] i_req_wdata;
  logic [STRB_W-1:0] i_req_strb;
  logic              o_rsp_valid;
  logic              i_rsp_ready = 1'b0;
  logic [DATA_W-1:0] o_rsp_data;
  logic [RESP_W-1:0] o_rsp_resp;

  // one entry per transaction in the vector file
  logic              vec_write[$];
  logic [ADDR_W-1:0] vec_addr[$];
  logic [DATA_W-1:0] vec_wdata[$];
  logic [STRB_W-1:0] vec_strb[$];
  logic [DATA_W-1:0] vec_data[$];
  logic [RESP_W-1:0] vec_resp[$];

  int   seed = 32'h0496c2a9;
  int   rnd;
  int   cycles = 0;
  int   cycle_limit = 0;
  logic pending = 1'b0;

  soc_fabric UUT (
    .i_pad_clk   (clk),
    .i_rst_n     (rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .i_req_strb  (i_req_strb),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_data  (o_rsp_data),
    .o_rsp_resp  (o_rsp_resp)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      abort_run("response value mismatch");
    end
  endtask

  // random back-pressure on the response channel
  always @(posedge clk) begin
    #0.5;
    rnd = $random(seed);
    i_rsp_ready = rnd[0];
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run("timeout: a response never arrived within the cycle limit");
    end
  end

  // handshake rules, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (pending && o_req_ready) begin
        abort_run("o_req_ready was high while a response was still pending");
      end
      if (!pending && o_rsp_valid) begin
        abort_run("o_rsp_valid was high with no request outstanding");
      end
    end
  end

  task automatic load_vectors();
    int                fd;
    int                n;
    string             line;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    fd = $fopen("sim/fabric_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("could not open sim/fabric_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h %h", we, addr, wdata, strb, data, resp);
      if (n == 6) begin
        vec_write.push_back(we);
        vec_addr.push_back(addr);
        vec_wdata.push_back(wdata);
        vec_strb.push_back(strb);
        vec_data.push_back(data);
        vec_resp.push_back(resp);
      end else if (n > 0) begin
        abort_run("malformed line in the vector file");
      end
    end
    $fclose(fd);
  endtask

  // one request, one response; entered and left 0.5 ns after an edge
  task automatic run_vector(input int i);
    logic [DATA_W-1:0] got_data;
    logic [DATA_W-1:0] got_resp;
    bit                got;
    got = 1'b0;
    i_req_valid = 1'b1;
    i_req_write = vec_write[i];
    i_req_addr  = vec_addr[i];
    i_req_wdata = vec_wdata[i];
    i_req_strb  = vec_strb[i];
    do begin
      @(negedge clk);
    end while (!o_req_ready);
    @(posedge clk);
    pending = 1'b1;
    #0.5;
    i_req_valid = 1'b0;
    while (!got) begin
      @(negedge clk);
      if (o_rsp_valid && i_rsp_ready) begin
        got_data = o_rsp_data;
        got_resp = DATA_W'(o_rsp_resp);
        got = 1'b1;
      end
    end
    @(posedge clk);
    pending = 1'b0;
    compare_value($sformatf("vector %0d data", i + 1), vec_data[i], got_data);
    compare_value($sformatf("vector %0d resp", i + 1), DATA_W'(vec_resp[i]), got_resp);
    #0.5;
  endtask

  initial begin
    rst_n       = 1'b0;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_req_strb  = '0;
    load_vectors();
    cycle_limit = 20 * vec_addr.size() + 50;
    repeat (2) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    for (int i = 0; i < vec_addr.size(); i++) begin
      run_vector(i);
    end
    if (vec_addr.size() > 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("no transactions were read from the vector file");
    end
  end

endmodule

/* rtl/soc_fabric.sv */
//**********************************************************
// Bus fabric top. One master request channel is steered to
// the SRAM or the system register block, and the replies
// come back merged on one response channel.
//**********************************************************

`timescale 1ns/100ps

module soc_fabric import soc_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic              i_pad_clk,
  input  logic              i_rst_n,
  // request channel
  input  logic              i_req_valid,
  output logic              o_req_ready,
  input  logic              i_req_write,
  input  logic [ADDR_W-1:0] i_req_addr,
  input  logic [DATA_W-1:0] i_req_wdata,
  input  logic [STRB_W-1:0] i_req_strb,
  // response channel
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output logic [DATA_W-1:0] o_rsp_data,
  output logic [RESP_W-1:0] o_rsp_resp
);

  logic done;

  slv_if sram_bus ();
  slv_if regs_bus ();

  bus_decoder #(
    .SRAM_WORDS (SRAM_WORDS)
  ) x_bus_decoder (
    .i_pad_clk   (i_pad_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_write (i_req_write),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .i_req_strb  (i_req_strb),
    .i_done      (done),
    .sram_bus    (sram_bus.initiator),
    .regs_bus    (regs_bus.initiator)
  );

  sram_slave #(
    .SRAM_WORDS (SRAM_WORDS)
  ) x_sram_slave (
    .i_pad_clk (i_pad_clk),
    .i_rst_n   (i_rst_n),
    .bus       (sram_bus.target)
  );

  // also the default target for unmapped regions
  sys_regs x_sys_regs (
    .i_pad_clk (i_pad_clk),
    .i_rst_n   (i_rst_n),
    .bus       (regs_bus.target)
  );

  rsp_mux x_rsp_mux (
    .i_pad_clk   (i_pad_clk),
    .i_rst_n     (i_rst_n),
    .sram_bus    (sram_bus.collect),
    .regs_bus    (regs_bus.collect),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_data  (o_rsp_data),
    .o_rsp_resp  (o_rsp_resp),
    .o_done      (done)
  );

endmodule

/* rtl/rsp_mux.sv */
//**********************************************************
// Response stage. Captures the reply of whichever target
// acked and holds it on the master response channel until
// it is taken; signals done on that handshake.
//**********************************************************

`timescale 1ns/100ps

module rsp_mux import soc_pkg::*; (
  input  logic              i_pad_clk,
  input  logic              i_rst_n,
  slv_if.collect            sram_bus,
  slv_if.collect            regs_bus,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output logic [DATA_W-1:0] o_rsp_data,
  output logic [RESP_W-1:0] o_rsp_resp,
  output logic              o_done
);

  logic any_ack;

  assign any_ack = sram_bus.ack | regs_bus.ack;
  assign o_done  = o_rsp_valid & i_rsp_ready;

  // one transaction in flight, so ack never meets a handshake
  always_ff @(posedge i_pad_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (any_ack) begin
      o_rsp_valid <= 1'b1;
    end else if (o_done) begin
      o_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (sram_bus.ack) begin
      o_rsp_data <= sram_bus.rdata;
      o_rsp_resp <= sram_bus.resp;
    end else if (regs_bus.ack) begin
      o_rsp_data <= regs_bus.rdata;
      o_rsp_resp <= regs_bus.resp;
    end
  end

endmodule

/* rtl/sys_regs.sv */
//**********************************************************
// System register block and default target. Region 1 maps
// scratch, fault count and ID; any other region gets a
// decode error and bumps the fault counter.
//**********************************************************

`timescale 1ns/100ps

module sys_regs import soc_pkg::*; (
  input  logic     i_pad_clk,
  input  logic     i_rst_n,
  slv_if.target    bus
);

  logic [REG_W-1:0]  scratch;
  logic [REG_W-1:0]  faults;
  logic              in_region;
  logic [1:0]        offset;
  logic [REG_W-1:0]  rd_next;
  logic [RESP_W-1:0] resp_next;
  logic              scratch_we;
  logic              fault_hit;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;
  logic [RESP_W-1:0] resp_q;

  assign in_region = (bus.addr[REGION_MSB:REGION_LSB] == REGION_REGS);
  assign offset    = bus.addr[5:4];

  always_comb begin
    rd_next    = '0;
    resp_next  = RESP_OKAY;
    scratch_we = 1'b0;
    fault_hit  = 1'b0;
    if (!in_region) begin
      resp_next = RESP_DECERR;
      fault_hit = bus.stb;
    end else begin
      case (offset)
        REG_SCRATCH: begin
          if (bus.we) scratch_we = bus.stb;
          else        rd_next    = scratch;
        end
        REG_FAULTS: begin
          if (bus.we) resp_next = RESP_SLVERR;
          else        rd_next   = faults;
        end
        REG_ID: begin
          if (bus.we) resp_next = RESP_SLVERR;
          else        rd_next   = SOC_ID;
        end
        // reserved slot reads zero
        default: rd_next = '0;
      endcase
    end
  end

  always_ff @(posedge i_pad_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q   <= 1'b0;
      scratch <= '0;
      faults  <= '0;
    end else begin
      ack_q <= bus.stb;
      if (fault_hit) faults <= faults + 1'b1;
      if (scratch_we) begin
        for (int b = 0; b < REG_W / 8; b++) begin
          if (bus.strb[b]) scratch[8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (bus.stb) begin
      rdata_q <= DATA_W'(rd_next);
      resp_q  <= resp_next;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign bus.resp  = resp_q;

endmodule

/* rtl/sram_slave.sv */
//**********************************************************
// 128-bit synchronous SRAM target with byte strobes.
// Answers every strobe one cycle later with OKAY; reads
// return the stored word, writes return zero data.
//**********************************************************

`timescale 1ns/100ps

module sram_slave import soc_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic     i_pad_clk,
  input  logic     i_rst_n,
  slv_if.target    bus
);

  localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx = bus.addr[IDX_W-1:0];

  // byte lanes under strb
  always_ff @(posedge i_pad_clk) begin
    if (bus.stb && bus.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.strb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (bus.stb) begin
      rdata_q <= bus.we ? '0 : mem[idx];
    end
  end

  always_ff @(posedge i_pad_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.stb;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;
  assign bus.resp  = RESP_OKAY;

endmodule

/* rtl/bus_decoder.sv */
//**********************************************************
// Request front end. Takes one master request at a time,
// registers it and strobes the target picked by the region
// field. Stays busy until the response has been taken.
//**********************************************************

`timescale 1ns/100ps

module bus_decoder import soc_pkg::*; #(
  parameter int unsigned SRAM_WORDS = 256
) (
  input  logic              i_pad_clk,
  input  logic              i_rst_n,
  input  logic              i_req_valid,
  output logic              o_req_ready,
  input  logic              i_req_write,
  input  logic [ADDR_W-1:0] i_req_addr,
  input  logic [DATA_W-1:0] i_req_wdata,
  input  logic [STRB_W-1:0] i_req_strb,
  input  logic              i_done,
  slv_if.initiator          sram_bus,
  slv_if.initiator          regs_bus
);

  localparam int unsigned IDX_LSB = $clog2(STRB_W);
  localparam int unsigned IDX_W   = $clog2(SRAM_WORDS);

  logic              busy;
  logic              drain;
  logic              accept;
  logic              to_sram;
  logic              sram_stb;
  logic              regs_stb;
  logic              req_we;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [STRB_W-1:0] req_strb;

  assign o_req_ready = ~busy;
  assign accept      = i_req_valid & ~busy;
  assign to_sram     = (i_req_addr[REGION_MSB:REGION_LSB] == REGION_SRAM);

  // busy drops one edge after the response handshake
  always_ff @(posedge i_pad_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      drain    <= 1'b0;
      sram_stb <= 1'b0;
      regs_stb <= 1'b0;
    end else begin
      drain    <= i_done;
      sram_stb <= accept & to_sram;
      regs_stb <= accept & ~to_sram;
      if (accept) begin
        busy <= 1'b1;
      end else if (drain) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_pad_clk) begin
    if (accept) begin
      req_we    <= i_req_write;
      req_addr  <= i_req_addr;
      req_wdata <= i_req_wdata;
      req_strb  <= i_req_strb;
    end
  end

  // sram sees a word index, wrapping past the depth
  assign sram_bus.stb   = sram_stb;
  assign sram_bus.we    = req_we;
  assign sram_bus.addr  = ADDR_W'(req_addr[IDX_LSB +: IDX_W]);
  assign sram_bus.wdata = req_wdata;
  assign sram_bus.strb  = req_strb;

  assign regs_bus.stb   = regs_stb;
  assign regs_bus.we    = req_we;
  assign regs_bus.addr  = req_addr;
  assign regs_bus.wdata = req_wdata;
  assign regs_bus.strb  = req_strb;

endmodule

/* rtl/slv_if.sv */
//**********************************************************
// Single-channel target link between the decoder, one
// target and the response stage. Strobe and payload go
// out, a one-cycle ack with data and response comes back.
//**********************************************************

`timescale 1ns/100ps

interface slv_if import soc_pkg::*; ();

  logic              stb;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] strb;

  logic              ack;
  logic [DATA_W-1:0] rdata;
  logic [RESP_W-1:0] resp;

  modport initiator (
    output stb, we, addr, wdata, strb
  );

  modport target (
    input  stb, we, addr, wdata, strb,
    output ack, rdata, resp
  );

  // response side only
  modport collect (
    input ack, rdata, resp
  );

endinterface

/* rtl/soc_pkg.sv */
//**********************************************************
// Shared constants for the bus fabric: widths, the region
// map, system register offsets and response codes.
//**********************************************************

package soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 128;
  localparam int unsigned STRB_W = DATA_W / 8;

  // region select field of the address
  localparam int unsigned REGION_MSB = 31;
  localparam int unsigned REGION_LSB = 28;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_SRAM = 'd0;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_REGS = 'd1;

  // response codes, AXI style
  localparam int unsigned RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

  // system register offsets, address bits 5:4
  localparam logic [1:0] REG_SCRATCH = 2'd0;
  localparam logic [1:0] REG_FAULTS  = 2'd1;
  localparam logic [1:0] REG_ID      = 2'd2;
  localparam logic [1:0] REG_RSVD    = 2'd3;

  localparam int unsigned REG_W = 32;
  localparam logic [REG_W-1:0] SOC_ID = 32'h5f1a_0c91;

endpackage
